// ==== asg_pkg.sv ====
package asg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // fixed width types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [16-1:0] cyc_t;   // burst data cycles
  typedef logic [32-1:0] dly_t;   // burst delay cycles
  typedef logic [16-1:0] rep_t;   // burst repetitions
  typedef logic [32-1:0] word_t;  // cpu bus word

  // sequencer states
  typedef enum logic [2-1:0] {
    SEQ_IDLE  = 2'b00,  // wait for trigger
    SEQ_DATA  = 2'b01,  // samples going out
    SEQ_DELAY = 2'b10   // pause between bursts
  } seq_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [3-1:0] REG_CTRL = 3'd0;  // control bits
  localparam logic [3-1:0] REG_SIZE = 3'd1;  // table size, fixed point
  localparam logic [3-1:0] REG_STEP = 3'd2;  // pointer step
  localparam logic [3-1:0] REG_OFFS = 3'd3;  // start offset
  localparam logic [3-1:0] REG_BCYC = 3'd4;  // samples per burst - 1
  localparam logic [3-1:0] REG_BDLY = 3'd5;  // pause length
  localparam logic [3-1:0] REG_BNUM = 3'd6;  // number of bursts

  // control register bits
  localparam int unsigned CTRL_CLR  = 0;  // self clearing
  localparam int unsigned CTRL_TRG  = 1;  // self clearing
  localparam int unsigned CTRL_BENA = 2;
  localparam int unsigned CTRL_BINF = 3;

endpackage : asg_pkg

// ==== asg_regs.sv ====
`timescale 1ns/100ps

module asg_regs #(
  int unsigned DWO = 14,  // sample width
  int unsigned CWM = 8,   // table index width
  int unsigned CWF = 16   // pointer fraction width
)(
  input  logic                   clk,
  input  logic                   ctl_rst,
  // cpu bus
  input  logic                   bus_ena,
  input  logic                   bus_wen,
  input  logic [CWM:0]           bus_addr,   // top bit selects table
  input  asg_pkg::word_t         bus_wdata,
  output asg_pkg::word_t         bus_rdata,
  // configuration
  output logic [CWM+CWF-1:0]     cfg_size,
  output logic [CWM+CWF-1:0]     cfg_step,
  output logic [CWM+CWF-1:0]     cfg_offs,
  output logic                   cfg_bena,
  output logic                   cfg_binf,
  output asg_pkg::cyc_t          cfg_bcyc,
  output asg_pkg::dly_t          cfg_bdly,
  output asg_pkg::rep_t          cfg_bnum,
  // control pulses
  output logic                   sw_clr,
  output logic                   sw_trg,
  // table port
  output logic                   tbl_wen,
  output logic                   tbl_ren,
  output logic [CWM-1:0]         tbl_addr,
  output logic signed [DWO-1:0]  tbl_wdata,
  input  logic signed [DWO-1:0]  tbl_rdata   // one cycle after tbl_ren
);

  import asg_pkg::*;

  logic  reg_wen;   // register write this cycle
  logic  reg_ren;   // register read this cycle
  word_t reg_mux;   // register read-back, combinational
  word_t reg_rdata;
  logic  rd_tbl;    // last read went to the table

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign reg_wen = bus_ena &  bus_wen & ~bus_addr[CWM];
  assign reg_ren = bus_ena & ~bus_wen & ~bus_addr[CWM];

  assign tbl_wen   = bus_ena &  bus_wen & bus_addr[CWM];
  assign tbl_ren   = bus_ena & ~bus_wen & bus_addr[CWM];
  assign tbl_addr  = bus_addr[CWM-1:0];
  assign tbl_wdata = bus_wdata[DWO-1:0];  // low bits only

  // register file plus self clearing ctrl pulses
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      cfg_size <= '0;
      cfg_step <= '0;
      cfg_offs <= '0;
      cfg_bena <= 1'b0;
      cfg_binf <= 1'b0;
      cfg_bcyc <= '0;
      cfg_bdly <= '0;
      cfg_bnum <= '0;
      sw_clr   <= 1'b0;
      sw_trg   <= 1'b0;
    end else begin
      sw_clr <= 1'b0;  // pulses last one cycle
      sw_trg <= 1'b0;
      if (reg_wen) begin
        case (bus_addr[2:0])
          REG_CTRL: begin
            sw_clr   <= bus_wdata[CTRL_CLR];
            sw_trg   <= bus_wdata[CTRL_TRG];
            cfg_bena <= bus_wdata[CTRL_BENA];
            cfg_binf <= bus_wdata[CTRL_BINF];
          end
          REG_SIZE: cfg_size <= bus_wdata[CWM+CWF-1:0];
          REG_STEP: cfg_step <= bus_wdata[CWM+CWF-1:0];
          REG_OFFS: cfg_offs <= bus_wdata[CWM+CWF-1:0];
          REG_BCYC: cfg_bcyc <= cyc_t'(bus_wdata);
          REG_BDLY: cfg_bdly <= dly_t'(bus_wdata);
          REG_BNUM: cfg_bnum <= rep_t'(bus_wdata);
          default: ;  // index 7 unused
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_mux = '0;
    case (bus_addr[2:0])
      REG_CTRL: begin
        reg_mux[CTRL_BENA] = cfg_bena;  // clr/trg read as zero
        reg_mux[CTRL_BINF] = cfg_binf;
      end
      REG_SIZE: reg_mux = word_t'(cfg_size);
      REG_STEP: reg_mux = word_t'(cfg_step);
      REG_OFFS: reg_mux = word_t'(cfg_offs);
      REG_BCYC: reg_mux = word_t'(cfg_bcyc);
      REG_BDLY: reg_mux = word_t'(cfg_bdly);
      REG_BNUM: reg_mux = word_t'(cfg_bnum);
      default:  reg_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_ren) reg_rdata <= reg_mux;  // held until next register read
  end

  // which source answered the last read
  always_ff @(posedge clk) begin
    if (ctl_rst) begin
      rd_tbl <= 1'b0;
    end else if (bus_ena & ~bus_wen) begin
      rd_tbl <= bus_addr[CWM];
    end
  end

  // table samples sign extended to bus width
  assign bus_rdata = rd_tbl ? {{($bits(word_t)-DWO){tbl_rdata[DWO-1]}}, tbl_rdata}
                            : reg_rdata;

endmodule : asg_regs

// ==== asg_seq.sv ====
`timescale 1ns/100ps

module asg_seq #(
  int unsigned CWM = 8,   // table index width
  int unsigned CWF = 16   // pointer fraction width
)(
  input  logic                clk,
  input  logic                ctl_rst,
  // triggers and clear
  input  logic                trg_in,    // external, pulse or level
  input  logic                sw_clr,
  input  logic                sw_trg,
  // configuration
  input  logic [CWM+CWF-1:0]  cfg_size,
  input  logic [CWM+CWF-1:0]  cfg_step,
  input  logic [CWM+CWF-1:0]  cfg_offs,
  input  logic                cfg_bena,
  input  logic                cfg_binf,
  input  asg_pkg::cyc_t       cfg_bcyc,
  input  asg_pkg::dly_t       cfg_bdly,
  input  asg_pkg::rep_t       cfg_bnum,
  // stream read request
  output logic                rd_en,
  output logic [CWM-1:0]      rd_idx,
  output logic                trg_o      // burst start marker
);

  import asg_pkg::*;

  seq_state_t state;

  cyc_t cnt_cyc;  // data cycles left in burst
  dly_t cnt_dly;  // pause cycles left
  rep_t cnt_rep;  // bursts left, current one included

  logic [CWM+CWF-1:0] ptr;      // fixed point read pointer
  logic [CWM+CWF  :0] ptr_sum;  // extra bit for overflow
  logic [CWM+CWF-1:0] ptr_nxt;
  logic               ptr_wrap;

  logic start;    // trigger accepted from idle
  logic bst_end;  // last cycle of a burst incl. pause
  logic restart;  // next burst follows directly

  ////////////////////////////////////////////////////////////////////////////
  // trigger and burst decisions
  ////////////////////////////////////////////////////////////////////////////

  // triggers only count in idle, ignored while running
  assign start = (trg_in | sw_trg) & (state == SEQ_IDLE);

  assign bst_end = cfg_bena &
                   (((state == SEQ_DATA) & (cnt_cyc == '0) & (cnt_dly == '0)) |
                    ((state == SEQ_DELAY) & (cnt_dly == '0)));

  assign restart = bst_end & (cfg_binf | (cnt_rep > rep_t'(1)));

  assign trg_o = start | restart;  // one pulse per burst

  ////////////////////////////////////////////////////////////////////////////
  // modulo pointer
  ////////////////////////////////////////////////////////////////////////////

  assign ptr_sum  = {1'b0, ptr} + {1'b0, cfg_step};
  assign ptr_wrap = ptr_sum > {1'b0, cfg_size};  // past last entry
  always_comb begin
    if (ptr_wrap) ptr_nxt = ptr_sum[CWM+CWF-1:0] - cfg_size - 1'b1;
    else          ptr_nxt = ptr_sum[CWM+CWF-1:0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // state machine and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ctl_rst | sw_clr) begin
      state   <= SEQ_IDLE;
      cnt_cyc <= '0;
      cnt_dly <= '0;
      cnt_rep <= '0;
      ptr     <= '0;
    end else if (trg_o) begin
      // new burst, from idle or back to back
      state   <= SEQ_DATA;
      cnt_cyc <= cfg_bcyc;
      cnt_dly <= cfg_bdly;
      if (start)         cnt_rep <= cfg_bnum;
      else if (!cfg_binf) cnt_rep <= cnt_rep - 1'b1;
      ptr     <= cfg_offs;  // every burst restarts at offset
    end else begin
      case (state)
        SEQ_DATA: begin
          ptr <= ptr_nxt;
          if (cfg_bena) begin  // continuous mode never leaves
            if (cnt_cyc != '0)      cnt_cyc <= cnt_cyc - 1'b1;
            else if (cnt_dly != '0) state   <= SEQ_DELAY;
            else                    state   <= SEQ_IDLE;  // last burst, no pause
          end
        end
        SEQ_DELAY: begin
          if (cnt_dly != '0) cnt_dly <= cnt_dly - 1'b1;
          else               state   <= SEQ_IDLE;  // all bursts played
        end
        default: ;  // idle waits for trigger
      endcase
    end
  end

  // read request toward table
  assign rd_en  = (state == SEQ_DATA);
  assign rd_idx = ptr[CWF +: CWM];  // integer part

endmodule : asg_seq

// ==== asg_buf.sv ====
`timescale 1ns/100ps

module asg_buf #(
  int unsigned DWO = 14,  // sample width
  int unsigned CWM = 8    // table index width
)(
  input  logic                   clk,
  input  logic                   ctl_rst,
  input  logic                   sw_clr,     // flush valid pipe
  // stream read from sequencer
  input  logic                   rd_en,
  input  logic [CWM-1:0]         rd_idx,
  // cpu table port
  input  logic                   tbl_wen,
  input  logic                   tbl_ren,
  input  logic [CWM-1:0]         tbl_addr,
  input  logic signed [DWO-1:0]  tbl_wdata,
  output logic signed [DWO-1:0]  tbl_rdata,
  // sample stream
  output logic signed [DWO-1:0]  sto_dat,
  output logic                   sto_vld
);

  logic signed [DWO-1:0] mem [0:2**CWM-1];  // sample table

  logic [CWM-1:0]        rd_addr;  // stage 1 address
  logic                  rd_vld;   // stage 1 valid
  logic signed [DWO-1:0] rd_data;  // stage 2 data

  ////////////////////////////////////////////////////////////////////////////
  // cpu side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (tbl_wen) mem[tbl_addr] <= tbl_wdata;
  end

  always_ff @(posedge clk) begin
    if (tbl_ren) tbl_rdata <= mem[tbl_addr];  // holds between reads
  end

  ////////////////////////////////////////////////////////////////////////////
  // stream side, address then data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_en)  rd_addr <= rd_idx;
    if (rd_vld) rd_data <= mem[rd_addr];
  end

  // valid travels with address and data
  always_ff @(posedge clk) begin
    if (ctl_rst | sw_clr) begin
      rd_vld  <= 1'b0;
      sto_vld <= 1'b0;
    end else begin
      rd_vld  <= rd_en;
      sto_vld <= rd_vld;
    end
  end

  assign sto_dat = sto_vld ? rd_data : '0;  // quiet bus when idle

endmodule : asg_buf

// ==== asg_top.sv ====
`timescale 1ns/100ps

module asg_top #(
  int unsigned DWO = 14,  // sample width
  int unsigned CWM = 8,   // table index width
  int unsigned CWF = 16   // pointer fraction width
)(
  input  logic                   clk,
  input  logic                   ctl_rst,
  // cpu bus
  input  logic                   bus_ena,
  input  logic                   bus_wen,
  input  logic [CWM:0]           bus_addr,
  input  asg_pkg::word_t         bus_wdata,
  output asg_pkg::word_t         bus_rdata,
  // trigger
  input  logic                   trg_in,
  output logic                   trg_o,
  // dac stream
  output logic signed [DWO-1:0]  sto_dat,
  output logic                   sto_vld
);

  import asg_pkg::*;

  // configuration
  logic [CWM+CWF-1:0] cfg_size;
  logic [CWM+CWF-1:0] cfg_step;
  logic [CWM+CWF-1:0] cfg_offs;
  logic               cfg_bena;
  logic               cfg_binf;
  cyc_t               cfg_bcyc;
  dly_t               cfg_bdly;
  rep_t               cfg_bnum;
  logic               sw_clr;
  logic               sw_trg;

  // table port
  logic                  tbl_wen;
  logic                  tbl_ren;
  logic [CWM-1:0]        tbl_addr;
  logic signed [DWO-1:0] tbl_wdata;
  logic signed [DWO-1:0] tbl_rdata;

  // stream request
  logic           rd_en;
  logic [CWM-1:0] rd_idx;

  ////////////////////////////////////////////////////////////////////////////
  // decode, sequencer, buffer
  ////////////////////////////////////////////////////////////////////////////

  asg_regs #(.DWO(DWO), .CWM(CWM), .CWF(CWF)) i_regs (
    .clk, .ctl_rst,
    .bus_ena, .bus_wen, .bus_addr, .bus_wdata, .bus_rdata,
    .cfg_size, .cfg_step, .cfg_offs, .cfg_bena, .cfg_binf,
    .cfg_bcyc, .cfg_bdly, .cfg_bnum,
    .sw_clr, .sw_trg,
    .tbl_wen, .tbl_ren, .tbl_addr, .tbl_wdata, .tbl_rdata
  );

  asg_seq #(.CWM(CWM), .CWF(CWF)) i_seq (
    .clk, .ctl_rst,
    .trg_in, .sw_clr, .sw_trg,
    .cfg_size, .cfg_step, .cfg_offs, .cfg_bena, .cfg_binf,
    .cfg_bcyc, .cfg_bdly, .cfg_bnum,
    .rd_en, .rd_idx, .trg_o
  );

  asg_buf #(.DWO(DWO), .CWM(CWM)) i_buf (
    .clk, .ctl_rst, .sw_clr,
    .rd_en, .rd_idx,
    .tbl_wen, .tbl_ren, .tbl_addr, .tbl_wdata, .tbl_rdata,
    .sto_dat, .sto_vld
  );

endmodule : asg_top

// ==== asg_sva.sv ====
`timescale 1ns/100ps

module asg_sva #(
  int unsigned CWM = 8,   // table index width
  int unsigned CWF = 16   // pointer fraction width
)(
  input logic                 clk,
  input logic                 ctl_rst,
  input asg_pkg::seq_state_t  state,
  input logic                 trg_o,
  input logic                 rd_en,
  input logic [CWM-1:0]       rd_idx,
  input logic [CWM+CWF-1:0]   cfg_size,
  input logic                 cfg_bena,
  input asg_pkg::cyc_t        cfg_bcyc
);

  import asg_pkg::*;

  logic [16:0] n_data;  // data cycles since last burst start

  always_ff @(posedge clk) begin
    if (ctl_rst || trg_o) n_data <= '0;
    else if (rd_en)       n_data <= n_data + 1'b1;
  end

  // while running only the end of a full burst may pulse trg_o
  trg_running: assert property (@(posedge clk) disable iff (ctl_rst)
    (trg_o && state != SEQ_IDLE) |->
      (cfg_bena && ((n_data + rd_en) == (cfg_bcyc + 17'd1))))
    else $error("trg_o high while running outside a burst restart");

  // data phase opens with a burst start and never outlasts one burst
  rd_en_data: assert property (@(posedge clk) disable iff (ctl_rst)
    rd_en |-> (($past(trg_o) || $past(rd_en)) && (!cfg_bena || n_data <= cfg_bcyc)))
    else $error("rd_en outside the data phase of a burst");

  reset_idle: assert property (@(posedge clk)
    ctl_rst |=> (state == SEQ_IDLE && !trg_o))
    else $error("sequencer not idle after reset");

  // pointer integer part never leaves the table
  idx_range: assert property (@(posedge clk) disable iff (ctl_rst)
    rd_en |-> (rd_idx <= cfg_size[CWF +: CWM]))
    else $error("rd_idx beyond the configured table size");

endmodule : asg_sva

bind asg_seq asg_sva #(.CWM(CWM), .CWF(CWF)) i_sva (
  .clk, .ctl_rst, .state, .trg_o, .rd_en, .rd_idx, .cfg_size, .cfg_bena, .cfg_bcyc
);

// ==== tb_asg.sv ====
`timescale 1ns/100ps

module tb_asg;

  import asg_pkg::*;

  localparam int unsigned DWO = 14;
  localparam int unsigned CWM = 8;
  localparam int unsigned CWF = 16;
  localparam int NCASE   = 6;
  localparam int TIMEOUT = 4000;  // cycles allowed per wait loop

  // one row per test case
  typedef struct packed {
    int size;
    int step;
    int offs;
    int bena;
    int binf;
    int bcyc;
    int bdly;
    int bnum;
    int src;   // 0 trg_in, 1 ctrl write, 2 trg_in plus retrigger
    int nchk;  // samples to compare
  } case_t;

  logic                  clk = 1'b0;
  logic                  ctl_rst;
  logic                  bus_ena;
  logic                  bus_wen;
  logic [CWM:0]          bus_addr;
  word_t                 bus_wdata;
  word_t                 bus_rdata;
  logic                  trg_in;
  logic                  trg_o;
  logic signed [DWO-1:0] sto_dat;
  logic                  sto_vld;

  case_t                 cases [NCASE];
  logic signed [DWO-1:0] tbl [2**CWM];  // shadow of table contents
  int                    exp_q [$];     // expected samples of current row
  logic [31:0]           rnd = 32'd35478;

  asg_top #(.DWO(DWO), .CWM(CWM), .CWF(CWF)) i_asg_top (
    .clk, .ctl_rst,
    .bus_ena, .bus_wen, .bus_addr, .bus_wdata, .bus_rdata,
    .trg_in, .trg_o,
    .sto_dat, .sto_vld
  );

  always #5 clk = ~clk;  // 10 ns period

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [CWM:0] reg_addr(input logic [2:0] idx);
    return {1'b0, {(CWM-3){1'b0}}, idx};  // top bit clear selects registers
  endfunction

  function automatic word_t ctrl_bits(input case_t c, input logic trg);
    word_t w;
    w = '0;
    w[CTRL_TRG]  = trg;
    w[CTRL_BENA] = (c.bena != 0);
    w[CTRL_BINF] = (c.binf != 0);
    return w;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (exp === act) else
      fail_stop($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic bus_write(input logic [CWM:0] addr, input word_t data);
    @(posedge clk);
    #1;
    bus_ena   = 1'b1;
    bus_wen   = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(posedge clk);
    #1;
    bus_ena = 1'b0;
    bus_wen = 1'b0;
  endtask

  task automatic bus_read(input logic [CWM:0] addr, output word_t data);
    @(posedge clk);
    #1;
    bus_ena  = 1'b1;
    bus_wen  = 1'b0;
    bus_addr = addr;
    @(posedge clk);
    #1;
    bus_ena = 1'b0;
    data    = bus_rdata;  // valid one cycle after access
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // register and table read-back
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_registers();
    word_t val;
    word_t rd;
    bus_write(reg_addr(REG_CTRL), 32'h0000_000C);  // bena and binf only
    bus_read(reg_addr(REG_CTRL), rd);
    check_word("bus_rdata ctrl", 32'h0000_000C, rd);
    for (int r = 1; r <= 6; r++) begin
      rnd = lcg_next(rnd);
      case (r)
        1, 2, 3: val = rnd & ((32'd1 << (CWM+CWF)) - 1);  // fixed point regs
        4, 6:    val = rnd & 32'h0000_FFFF;
        default: val = rnd;
      endcase
      bus_write(reg_addr(3'(r)), val);
      bus_read(reg_addr(3'(r)), rd);
      check_word($sformatf("bus_rdata reg %0d", r), val, rd);
    end
  endtask

  task automatic load_table();
    word_t val;
    word_t rd;
    for (int a = 0; a < 2**CWM; a++) begin
      rnd    = lcg_next(rnd);
      val    = rnd >> 8;          // upper bits must be ignored
      tbl[a] = val[DWO-1:0];
      bus_write({1'b1, CWM'(a)}, val);
    end
    for (int a = 0; a < 2**CWM; a++) begin
      bus_read({1'b1, CWM'(a)}, rd);
      check_word($sformatf("bus_rdata tbl[%0d]", a),
                 {{(32-DWO){tbl[a][DWO-1]}}, tbl[a]}, rd);  // sign extended
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model and playback
  ////////////////////////////////////////////////////////////////////////////

  task automatic configure(input case_t c);
    bus_write(reg_addr(REG_SIZE), word_t'(c.size));
    bus_write(reg_addr(REG_STEP), word_t'(c.step));
    bus_write(reg_addr(REG_OFFS), word_t'(c.offs));
    bus_write(reg_addr(REG_BCYC), word_t'(c.bcyc));
    bus_write(reg_addr(REG_BDLY), word_t'(c.bdly));
    bus_write(reg_addr(REG_BNUM), word_t'(c.bnum));
    bus_write(reg_addr(REG_CTRL), ctrl_bits(c, 1'b0));
  endtask

  // modulo pointer walk, restarted at offs for every burst
  task automatic build_expect(input case_t c);
    longint ptr;
    int     n;
    exp_q.delete();
    ptr = c.offs;
    n   = 0;
    while (exp_q.size() < c.nchk) begin
      exp_q.push_back(tbl[int'(ptr >> CWF)]);
      ptr = ptr + c.step;
      if (ptr > c.size) ptr = ptr - (longint'(c.size) + 1);  // wrap
      n++;
      if (c.bena != 0 && n == c.bcyc + 1) begin
        ptr = c.offs;
        n   = 0;
      end
    end
  endtask

  task automatic play_case(input case_t c, input int idx);
    int cyc;
    int got;
    int trg_cnt;
    int trg_first;
    int vld_first;
    cyc       = 0;
    got       = 0;
    trg_cnt   = 0;
    trg_first = -1;
    vld_first = -1;
    @(posedge clk);
    #1;
    if (c.src == 1) begin
      bus_ena   = 1'b1;                // software trigger through ctrl
      bus_wen   = 1'b1;
      bus_addr  = reg_addr(REG_CTRL);
      bus_wdata = ctrl_bits(c, 1'b1);
    end else begin
      trg_in = 1'b1;
    end
    while (got < c.nchk) begin
      @(negedge clk);                  // outputs settled
      if (trg_o) begin
        trg_cnt++;
        if (trg_first < 0) trg_first = cyc;
      end
      if (sto_vld) begin
        if (vld_first < 0) vld_first = cyc;
        assert (int'(sto_dat) == exp_q[got]) else
          fail_stop($sformatf("FAILED at %0t: sto_dat expected %0d got %0d (case %0d)",
                              $time, exp_q[got], sto_dat, idx));
        got++;
      end else begin
        assert (sto_dat == '0) else
          fail_stop($sformatf("FAILED at %0t: sto_dat expected 0 got %0d", $time, sto_dat));
      end
      @(posedge clk);
      #1;
      bus_ena = 1'b0;
      bus_wen = 1'b0;
      trg_in  = (c.src == 2 && cyc == 10);  // retrigger while running
      cyc++;
      if (cyc > TIMEOUT)
        fail_stop($sformatf("timeout in case %0d, only %0d of %0d samples seen",
                            idx, got, c.nchk));
    end
    assert (trg_first == ((c.src == 1) ? 1 : 0)) else
      fail_stop($sformatf("FAILED at %0t: trg_o cycle expected %0d got %0d",
                          $time, (c.src == 1) ? 1 : 0, trg_first));
    assert (vld_first == trg_first + 3) else
      fail_stop($sformatf("FAILED at %0t: sto_vld first cycle expected %0d got %0d",
                          $time, trg_first + 3, vld_first));
    if (c.bena != 0 && c.binf == 0) begin
      // finite bursts, channel must fall quiet
      for (int q = 0; q < c.bdly + 20; q++) begin
        @(negedge clk);
        assert (!sto_vld && !trg_o && sto_dat == '0) else
          fail_stop($sformatf("FAILED at %0t: sto_vld/trg_o/sto_dat expected 0/0/0 got %0b/%0b/%0d",
                              $time, sto_vld, trg_o, sto_dat));
      end
      assert (trg_cnt == c.bnum) else
        fail_stop($sformatf("FAILED at %0t: trg_o count expected %0d got %0d",
                            $time, c.bnum, trg_cnt));
    end else begin
      if (c.bena == 0) begin
        assert (trg_cnt == 1) else
          fail_stop($sformatf("FAILED at %0t: trg_o count expected 1 got %0d", $time, trg_cnt));
      end else begin
        assert (trg_cnt > c.bnum) else
          fail_stop($sformatf("FAILED at %0t: trg_o count expected >%0d got %0d",
                              $time, c.bnum, trg_cnt));
      end
      bus_write(reg_addr(REG_CTRL), 32'h0000_0001);  // software clear
      for (int q = 0; q < 12; q++) begin
        @(negedge clk);
        if (q >= 1) begin
          assert (!sto_vld && sto_dat == '0) else
            fail_stop($sformatf("FAILED at %0t: sto_vld/sto_dat expected 0/0 got %0b/%0d",
                                $time, sto_vld, sto_dat));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ctl_rst   = 1'b1;
    bus_ena   = 1'b0;
    bus_wen   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    trg_in    = 1'b0;
    //           size       step       offs       bena binf bcyc bdly bnum src nchk
    cases[0] = '{'hFF_FFFF, 'h1_0000,  'h0,       0,   0,   0,   0,   0,   0,  300};
    cases[1] = '{'h63_FFFF, 'h2_8000,  'hA_4000,  0,   0,   0,   0,   0,   1,  200};
    cases[2] = '{'h31_FFFF, 'h0_C000,  'h5_0000,  0,   0,   0,   0,   0,   2,  120};
    cases[3] = '{'hFF_FFFF, 'h3_0000,  'h20_0000, 1,   0,   9,   7,   3,   0,  30};
    cases[4] = '{'h3F_FFFF, 'h1_4000,  'h3_0000,  1,   0,   4,   0,   4,   1,  20};
    cases[5] = '{'h1F_FFFF, 'h7_0000,  'h1_0000,  1,   1,   5,   3,   2,   0,  36};
    repeat (3) @(posedge clk);
    #1;
    ctl_rst = 1'b0;
    check_registers();
    load_table();
    for (int i = 0; i < NCASE; i++) begin
      configure(cases[i]);
      build_expect(cases[i]);
      play_case(cases[i], i);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule : tb_asg

// ==== vlog.f ====
asg_pkg.sv
asg_regs.sv
asg_seq.sv
asg_buf.sv
asg_top.sv
asg_sva.sv
tb_asg.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_asg -o tb_asg -f vlog.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_asg > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
